/* hdl/rom_check_geom_pkg.sv */
// Fixed ROM geometry; TopCount must be a power of two and TopAw must be its log2
`default_nettype none

package rom_check_geom_pkg;

  // Every ROM word and every digest lane is one 32-bit word
  localparam int WordW = 32;

  // Total number of ROM words, including the expected digest at the top
  localparam int RomDepth = 64;

  // Number of words at the top of the ROM that hold the expected digest
  localparam int TopCount = 8;

  // Width of a ROM word address
  localparam int RomAw = 6;

  // Width of an index into the digest words
  localparam int TopAw = 3;

  // First address of the expected digest, the low image ends just below it
  localparam logic [RomAw-1:0] TopStartAddr = RomAw'(RomDepth - TopCount);

  // Digest layout puts lane 0 in the least significant word
  localparam int DigestW = TopCount * WordW;

endpackage

`default_nettype wire

/* hdl/rom_check_status_pkg.sv */
// State and boolean encodings are sparse; any value outside the listed ones counts as a fault
`default_nettype none

package rom_check_status_pkg;

  // Four-bit boolean, where only the two values below are legal
  typedef logic [3:0] mubi4_t;

  localparam mubi4_t Mubi4True  = 4'h6;
  localparam mubi4_t Mubi4False = 4'h9;

  // Checker FSM states
  // The low nibble of each state doubles as the done flag for the power manager
  // Only Done carries Mubi4True there, so a single flipped bit cannot fake completion
  typedef enum logic [9:0] {
    // Streaming the low image into the digest engine
    ReadingLow  = {6'b001011, Mubi4False},
    // Copying the expected digest while the engine finishes
    ReadingHigh = {6'b110100, Mubi4False},
    // ROM fully read, digest still pending
    RomAhead    = {6'b011110, Mubi4False},
    // Digest ready, top words still being read
    HashAhead   = {6'b100001, Mubi4False},
    // Word-serial compare of computed and expected digest
    Checking    = {6'b010010, Mubi4False},
    // Terminal state, ROM is handed to the bus
    Done        = {6'b101101, Mubi4True},
    // Terminal fault state
    Invalid     = {6'b111011, Mubi4False}
  } check_state_e;

endpackage

`default_nettype wire

/* hdl/rom_check_counter.sv */
// ROM must return read data exactly one cycle after the request; the walk runs once per reset
`timescale 1ns/1ns
`default_nettype none

module rom_check_counter
  import rom_check_geom_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             data_rdy_i,
  output logic             done_o,
  output logic [RomAw-1:0] read_addr_o,
  output logic             read_req_o,
  output logic [RomAw-1:0] data_addr_o,
  output logic             data_last_low_o
);

  logic             started_q;
  logic             done_q;
  logic [RomAw-1:0] addr_q;
  logic             go;
  logic             at_top;

  // The word on the data bus is consumed when the sink takes it
  // Nothing is on the bus in the first cycle after reset
  assign go     = started_q & data_rdy_i & ~done_q;
  assign at_top = (addr_q == RomAw'(RomDepth - 1));

  // addr_q always names the word now on the ROM data bus
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q <= 1'b0;
      done_q    <= 1'b0;
      addr_q    <= '0;
    end else begin
      started_q <= 1'b1;
      if (go) begin
        if (at_top) begin
          // Top word has returned, the walk is finished for good
          done_q <= 1'b1;
        end else begin
          addr_q <= addr_q + 1'b1;
        end
      end
    end
  end

  // Step to the next word when the current one is taken, otherwise re-read it
  // so that the same data is still on the bus in the next cycle
  assign read_addr_o = (go && !at_top) ? addr_q + 1'b1 : addr_q;

  // No request once the top word is consumed
  assign read_req_o = ~done_q & ~(go & at_top);

  assign data_addr_o = addr_q;

  // Marks the last word of the low image, the one just below the digest
  assign data_last_low_o = started_q & (addr_q == TopStartAddr - 1'b1);

  assign done_o = done_q;

endmodule

`default_nettype wire

/* hdl/rom_check_hash.sv */
// Keyed XOR absorber in place of a real hash; it accepts one image per reset and never fails
`timescale 1ns/1ns
`default_nettype none

module rom_check_hash
  import rom_check_geom_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               vld_i,
  input  logic               last_i,
  input  logic [WordW-1:0]   data_i,
  output logic               rdy_o,
  output logic               done_o,
  output logic [DigestW-1:0] digest_o
);

  logic [RomAw-1:0]   cnt_q;
  logic               stall_q;
  logic [1:0]         fin_q;
  logic [DigestW-1:0] digest_q;
  logic               xfer;
  logic [TopAw-1:0]   lane;
  logic [WordW-1:0]   mixed;

  // One bubble after each fourth word stands in for the permutation rounds
  assign rdy_o = ~stall_q;
  assign xfer  = vld_i & rdy_o;

  // Words arrive in address order, so the accepted count is the word address
  assign lane  = cnt_q[TopAw-1:0];

  // The address acts as the key and is added before folding into the lane
  assign mixed = data_i + WordW'(cnt_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q    <= '0;
      stall_q  <= 1'b0;
      fin_q    <= '0;
      digest_q <= '0;
    end else begin
      stall_q <= xfer & (cnt_q[1:0] == 2'b11);
      // Two-stage finish pipeline after the last word
      fin_q   <= {fin_q[0], xfer & last_i};
      if (xfer) begin
        cnt_q <= cnt_q + 1'b1;
        digest_q[lane*WordW +: WordW] <= digest_q[lane*WordW +: WordW] ^ mixed;
      end
    end
  end

  // Digest already holds the last word when done fires
  assign done_o   = fin_q[1];
  assign digest_o = digest_q;

endmodule

`default_nettype wire

/* hdl/rom_check_compare.sv */
// Expected words must all be written before start_i; the index check relies on TopCount = 2**TopAw
`timescale 1ns/1ns
`default_nettype none

module rom_check_compare
  import rom_check_geom_pkg::*;
  import rom_check_status_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               exp_we_i,
  input  logic [TopAw-1:0]   exp_idx_i,
  input  logic [WordW-1:0]   exp_data_i,
  input  logic [DigestW-1:0] digest_i,
  input  logic               start_i,
  output logic [DigestW-1:0] exp_digest_o,
  output logic               done_o,
  output mubi4_t             good_o,
  output logic               alert_o
);

  logic [WordW-1:0] exp_q [TopCount];
  logic [TopAw:0]   idx_q;
  logic             busy_q;
  logic             mismatch_q;
  logic             done_q;
  mubi4_t           good_q;
  logic [TopAw-1:0] word_idx;
  logic             word_diff;
  logic             last_word;

  // Expected digest register file, filled one word at a time by the FSM snoop
  always_ff @(posedge clk_i) begin
    if (exp_we_i) begin
      exp_q[exp_idx_i] <= exp_data_i;
    end
  end

  for (genvar k = 0; k < TopCount; k++) begin : g_exp_out
    assign exp_digest_o[k*WordW +: WordW] = exp_q[k];
  end

  assign word_idx  = idx_q[TopAw-1:0];
  assign word_diff = (exp_q[word_idx] != digest_i[word_idx*WordW +: WordW]);
  assign last_word = (idx_q == {1'b0, TopAw'(TopCount - 1)});

  // One word per cycle; done and good land together after the last word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      idx_q      <= '0;
      mismatch_q <= 1'b0;
      done_q     <= 1'b0;
      good_q     <= Mubi4False;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        busy_q     <= 1'b1;
        idx_q      <= '0;
        mismatch_q <= 1'b0;
        good_q     <= Mubi4False;
      end else if (busy_q) begin
        idx_q      <= idx_q + 1'b1;
        mismatch_q <= mismatch_q | word_diff;
        if (last_word) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
          good_q <= (mismatch_q | word_diff) ? Mubi4False : Mubi4True;
        end
      end
    end
  end

  assign done_o = done_q;
  assign good_o = good_q;

  // While busy the index must stay below TopCount, and it rests at TopCount once finished
  // Anything beyond that means the walk was disturbed
  assign alert_o = busy_q ? idx_q[TopAw] : (idx_q[TopAw] & |idx_q[TopAw-1:0]);

endmodule

`default_nettype wire

/* hdl/rom_check_fsm.sv */
// Runs one check per reset; the only exits from the linear flow are Done and the fault state Invalid
`timescale 1ns/1ns
`default_nettype none

module rom_check_fsm
  import rom_check_geom_pkg::*;
  import rom_check_status_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               hash_rdy_i,
  input  logic               hash_done_i,
  input  logic [DigestW-1:0] hash_digest_i,
  input  logic [WordW-1:0]   rom_data_i,
  output logic               hash_vld_o,
  output logic               hash_last_o,
  output logic               rom_req_o,
  output logic [RomAw-1:0]   rom_addr_o,
  output mubi4_t             rom_sel_bus_o,
  output logic [DigestW-1:0] exp_digest_o,
  output mubi4_t             pwr_good_o,
  output mubi4_t             pwr_done_o,
  output logic               keymgr_valid_o,
  output logic               alert_o
);

  logic             counter_done;
  logic [RomAw-1:0] counter_read_addr;
  logic             counter_read_req;
  logic [RomAw-1:0] counter_data_addr;
  logic             counter_data_rdy;
  logic             counter_lnt;
  logic             start_q;
  logic             checker_done;
  logic             checker_alert;
  mubi4_t           checker_good;
  check_state_e     state_d, state_q;
  logic [9:0]       state_bits;
  mubi4_t           in_state_done;
  logic             fsm_alert;
  logic             counter_change;
  logic             reading_top;
  logic [RomAw-1:0] rel_addr;
  logic             hash_vld_d, hash_vld_q;

  rom_check_counter u_counter (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .data_rdy_i      (counter_data_rdy),
    .done_o          (counter_done),
    .read_addr_o     (counter_read_addr),
    .read_req_o      (counter_read_req),
    .data_addr_o     (counter_data_addr),
    .data_last_low_o (counter_lnt)
  );

  rom_check_compare u_compare (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .exp_we_i     (reading_top),
    .exp_idx_i    (rel_addr[TopAw-1:0]),
    .exp_data_i   (rom_data_i),
    .digest_i     (hash_digest_i),
    .start_i      (start_q),
    .exp_digest_o (exp_digest_o),
    .done_o       (checker_done),
    .good_o       (checker_good),
    .alert_o      (checker_alert)
  );

  // Any encoding outside the six working states is a fault, Invalid included
  assign fsm_alert = !(state_q inside {ReadingLow, ReadingHigh, RomAhead, HashAhead,
                                       Checking, Done});

  always_comb begin
    state_d = state_q;
    case (state_q)
      ReadingLow: begin
        // Leave once the last low word has gone into the digest engine
        if (counter_lnt && hash_rdy_i && hash_vld_q) begin
          state_d = ReadingHigh;
        end
      end
      ReadingHigh: begin
        // The ROM walk and the digest engine race here
        case ({hash_done_i, counter_done})
          2'b01:   state_d = RomAhead;
          2'b10:   state_d = HashAhead;
          2'b11:   state_d = Checking;
          default: state_d = ReadingHigh;
        endcase
      end
      RomAhead: begin
        if (hash_done_i) begin
          state_d = Checking;
        end
      end
      HashAhead: begin
        if (counter_done) begin
          state_d = Checking;
        end
      end
      Checking: begin
        if (checker_done) begin
          state_d = Done;
        end
      end
      Done: begin
        state_d = Done;
      end
      default: begin
        state_d = Invalid;
      end
    endcase

    // Done strobes outside the states that expect them mean the sequence was disturbed
    if ((checker_done && !(state_q inside {Checking, Done})) ||
        (counter_done && state_q == ReadingLow) ||
        (hash_done_i && !(state_q inside {ReadingHigh, RomAhead}))) begin
      state_d = Invalid;
    end

    // Every alert source pins the FSM in Invalid
    if (alert_o) begin
      state_d = Invalid;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ReadingLow;
    end else begin
      state_q <= state_d;
    end
  end

  // Low nibble of the state is the done flag without going through a single bit
  assign state_bits    = state_q;
  assign in_state_done = mubi4_t'(state_bits[3:0]);

  // Top words are copied while the counter still walks the high part
  assign reading_top = (state_q inside {ReadingHigh, HashAhead}) & ~counter_done;
  assign rel_addr    = counter_data_addr - TopStartAddr;

  // Valid follows every low read and holds until the engine takes the word
  always_comb begin
    hash_vld_d = hash_vld_q & ~hash_rdy_i;
    if (counter_read_req && state_q == ReadingLow && !counter_lnt) begin
      hash_vld_d = 1'b1;
    end
  end

  // start_q fires in the first cycle spent in Checking
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hash_vld_q <= 1'b0;
      start_q    <= 1'b0;
    end else begin
      hash_vld_q <= hash_vld_d;
      start_q    <= (state_q != Checking) && (state_d == Checking);
    end
  end

  // During the high part the counter never waits on the engine
  assign counter_data_rdy = hash_rdy_i | (state_q inside {ReadingHigh, HashAhead});
  assign hash_vld_o       = hash_vld_q;
  assign hash_last_o      = counter_lnt;

  // Once in Done the counter must still report done, or its address was tampered with
  assign counter_change = (in_state_done == Mubi4True) & ~counter_done;

  assign rom_sel_bus_o  = in_state_done;
  assign rom_req_o      = counter_read_req;
  assign rom_addr_o     = counter_read_addr;
  assign pwr_done_o     = in_state_done;
  assign pwr_good_o     = checker_good;
  assign keymgr_valid_o = (in_state_done == Mubi4True);
  assign alert_o        = fsm_alert | checker_alert | counter_change;

endmodule

`default_nettype wire

/* hdl/rom_check_mux.sv */
// Bus access is granted only on an exact Mubi4True select; read data is valid one cycle later
`timescale 1ns/1ns
`default_nettype none

module rom_check_mux
  import rom_check_geom_pkg::*;
  import rom_check_status_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  mubi4_t           sel_bus_i,
  input  logic             chk_req_i,
  input  logic [RomAw-1:0] chk_addr_i,
  input  logic             bus_req_i,
  input  logic [RomAw-1:0] bus_addr_i,
  input  logic [WordW-1:0] rom_data_i,
  output logic             rom_req_o,
  output logic [RomAw-1:0] rom_addr_o,
  output logic [WordW-1:0] bus_rdata_o,
  output logic             bus_rvalid_o
);

  logic sel_bus;
  logic rvalid_q;

  // Any corrupted select value falls back to the checker side
  assign sel_bus = (sel_bus_i == Mubi4True);

  assign rom_req_o  = sel_bus ? bus_req_i : chk_req_i;
  assign rom_addr_o = sel_bus ? bus_addr_i : chk_addr_i;

  // Bus requests made before the hand-over are dropped here
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= sel_bus & bus_req_i;
    end
  end

  assign bus_rvalid_o = rvalid_q;

  // Checker reads never show up on the bus data lines
  assign bus_rdata_o = rvalid_q ? rom_data_i : '0;

endmodule

`default_nettype wire

/* hdl/rom_check_top.sv */
// ROM storage sits outside and must answer every rom_req_o with data on the next cycle
`timescale 1ns/1ns
`default_nettype none

module rom_check_top
  import rom_check_geom_pkg::*;
  import rom_check_status_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [WordW-1:0]   rom_data_i,
  input  logic               bus_req_i,
  input  logic [RomAw-1:0]   bus_addr_i,
  output logic               rom_req_o,
  output logic [RomAw-1:0]   rom_addr_o,
  output logic [WordW-1:0]   bus_rdata_o,
  output logic               bus_rvalid_o,
  output mubi4_t             pwr_done_o,
  output mubi4_t             pwr_good_o,
  output logic               keymgr_valid_o,
  output logic [DigestW-1:0] keymgr_digest_o,
  output logic [DigestW-1:0] exp_digest_o,
  output logic               alert_o
);

  // Digest stream between the FSM and the engine
  logic               hash_vld;
  logic               hash_rdy;
  logic               hash_last;
  logic               hash_done;
  logic [DigestW-1:0] hash_digest;

  // Checker side of the ROM mux
  logic               chk_req;
  logic [RomAw-1:0]   chk_addr;
  mubi4_t             sel_bus;

  rom_check_fsm u_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .hash_rdy_i     (hash_rdy),
    .hash_done_i    (hash_done),
    .hash_digest_i  (hash_digest),
    .rom_data_i     (rom_data_i),
    .hash_vld_o     (hash_vld),
    .hash_last_o    (hash_last),
    .rom_req_o      (chk_req),
    .rom_addr_o     (chk_addr),
    .rom_sel_bus_o  (sel_bus),
    .exp_digest_o   (exp_digest_o),
    .pwr_good_o     (pwr_good_o),
    .pwr_done_o     (pwr_done_o),
    .keymgr_valid_o (keymgr_valid_o),
    .alert_o        (alert_o)
  );

  // The engine reads the ROM data bus directly
  rom_check_hash u_hash (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .vld_i    (hash_vld),
    .last_i   (hash_last),
    .data_i   (rom_data_i),
    .rdy_o    (hash_rdy),
    .done_o   (hash_done),
    .digest_o (hash_digest)
  );

  rom_check_mux u_mux (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .sel_bus_i    (sel_bus),
    .chk_req_i    (chk_req),
    .chk_addr_i   (chk_addr),
    .bus_req_i    (bus_req_i),
    .bus_addr_i   (bus_addr_i),
    .rom_data_i   (rom_data_i),
    .rom_req_o    (rom_req_o),
    .rom_addr_o   (rom_addr_o),
    .bus_rdata_o  (bus_rdata_o),
    .bus_rvalid_o (bus_rvalid_o)
  );

  assign keymgr_digest_o = hash_digest;

endmodule

`default_nettype wire

/* tests/rom_check_tb.sv */
// Fixed-seed random images, one per reset; the ROM array here answers each request one cycle later
`timescale 1ns/1ns
`default_nettype none

module rom_check_tb
  import rom_check_geom_pkg::*;
  import rom_check_status_pkg::*;
();

  localparam int NumImages    = 8;
  localparam int DoneTimeout  = 1000;
  localparam int NumBusCycles = 40;

  logic               clk_i;
  logic               rst_ni;
  logic [WordW-1:0]   rom_data_i;
  logic               bus_req_i;
  logic [RomAw-1:0]   bus_addr_i;
  logic               rom_req_o;
  logic [RomAw-1:0]   rom_addr_o;
  logic [WordW-1:0]   bus_rdata_o;
  logic               bus_rvalid_o;
  mubi4_t             pwr_done_o;
  mubi4_t             pwr_good_o;
  logic               keymgr_valid_o;
  logic [DigestW-1:0] keymgr_digest_o;
  logic [DigestW-1:0] exp_digest_o;
  logic               alert_o;

  // ROM contents and the digest the model expects for them
  logic [WordW-1:0]   rom_mem [RomDepth];
  logic [DigestW-1:0] model_dig;

  // Request seen late in the last low clock phase, answered on the next falling edge
  logic               rom_req_q;
  logic [RomAw-1:0]   rom_addr_q;

  // One bit per ROM address read by the checker before Done
  logic [RomDepth-1:0] seen_q;

  int unsigned fail_cnt;

  rom_check_top dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .rom_data_i      (rom_data_i),
    .bus_req_i       (bus_req_i),
    .bus_addr_i      (bus_addr_i),
    .rom_req_o       (rom_req_o),
    .rom_addr_o      (rom_addr_o),
    .bus_rdata_o     (bus_rdata_o),
    .bus_rvalid_o    (bus_rvalid_o),
    .pwr_done_o      (pwr_done_o),
    .pwr_good_o      (pwr_good_o),
    .keymgr_valid_o  (keymgr_valid_o),
    .keymgr_digest_o (keymgr_digest_o),
    .exp_digest_o    (exp_digest_o),
    .alert_o         (alert_o)
  );

  // Compares one value with its expected value and stops the run on a mismatch
  task automatic check_eq(input logic [DigestW-1:0] got, input logic [DigestW-1:0] exp,
                          input string what);
    if (got !== exp) begin
      fail_cnt++;
      $display("ERR @%0t: %s got %0h expected %0h", $time, what, got, exp);
      $display(">>> FAIL");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  // Digest word k folds in every low word whose address is k modulo TopCount
  function automatic logic [DigestW-1:0] model_digest();
    logic [DigestW-1:0] d;
    int                 base;
    d = '0;
    for (int a = 0; a < int'(TopStartAddr); a++) begin
      base = (a % TopCount) * WordW;
      d[base +: WordW] = d[base +: WordW] ^ (rom_mem[RomAw'(a)] + WordW'(a));
    end
    return d;
  endfunction

  // The expected digest as the top ROM words, lane 0 in the low word
  function automatic logic [DigestW-1:0] top_words();
    logic [DigestW-1:0] e;
    for (int k = 0; k < TopCount; k++) begin
      e[k*WordW +: WordW] = rom_mem[TopStartAddr + RomAw'(k)];
    end
    return e;
  endfunction

  // Random low image, digest on top, and optionally one top word spoiled
  task automatic load_image(input bit corrupt);
    logic [TopAw-1:0] bad_idx;
    for (int a = 0; a < int'(TopStartAddr); a++) begin
      rom_mem[RomAw'(a)] = $urandom;
    end
    model_dig = model_digest();
    for (int k = 0; k < TopCount; k++) begin
      rom_mem[TopStartAddr + RomAw'(k)] = model_dig[k*WordW +: WordW];
    end
    if (corrupt) begin
      bad_idx = TopAw'($urandom);
      // Setting bit 0 of the mask guarantees the word really changes
      rom_mem[TopStartAddr + RomAw'(bad_idx)] =
        rom_mem[TopStartAddr + RomAw'(bad_idx)] ^ ($urandom | 32'h1);
    end
  endtask

  // Waits for the power-manager done, firing bus requests that must be dropped
  task automatic wait_for_done();
    int unsigned cycles;
    bit          reached;
    cycles  = 0;
    reached = 1'b0;
    while (!reached && cycles < DoneTimeout) begin
      @(negedge clk_i);
      if (pwr_done_o == Mubi4True) begin
        reached = 1'b1;
      end else begin
        check_eq(DigestW'(pwr_done_o), DigestW'(Mubi4False), "pwr_done_o before Done");
        check_eq(DigestW'(bus_rvalid_o), DigestW'(1'b0), "bus_rvalid_o before Done");
        check_eq(DigestW'(keymgr_valid_o), DigestW'(1'b0), "keymgr_valid_o before Done");
        bus_req_i  = 1'($urandom);
        bus_addr_i = RomAw'($urandom);
        cycles++;
      end
    end
    bus_req_i = 1'b0;
    if (!reached) begin
      $display("Timed out after %0d cycles waiting for pwr_done_o to signal done", cycles);
      $display(">>> FAIL");
      $fatal(1, "No done from the checker");
    end
  endtask

  // Results that must hold once the checker has handed over the ROM
  task automatic check_done_outputs(input bit expect_good);
    check_eq(DigestW'(pwr_good_o), DigestW'(expect_good ? Mubi4True : Mubi4False),
             "pwr_good_o");
    check_eq(DigestW'(keymgr_valid_o), DigestW'(1'b1), "keymgr_valid_o in Done");
    check_eq(keymgr_digest_o, model_dig, "keymgr_digest_o");
    check_eq(exp_digest_o, top_words(), "exp_digest_o");
    check_eq(DigestW'(seen_q), DigestW'({RomDepth{1'b1}}), "ROM addresses read before Done");
  endtask

  // Random bus traffic; rvalid and the ROM word follow one cycle after each request
  task automatic random_bus_reads();
    logic             prev_req;
    logic [RomAw-1:0] prev_addr;
    prev_req  = 1'b0;
    prev_addr = '0;
    for (int n = 0; n < NumBusCycles; n++) begin
      @(negedge clk_i);
      bus_req_i  = 1'($urandom);
      bus_addr_i = RomAw'($urandom);
      // Give the ROM data driven on this edge time to settle
      #1;
      check_eq(DigestW'(bus_rvalid_o), DigestW'(prev_req), "bus_rvalid_o after Done");
      if (prev_req) begin
        check_eq(DigestW'(bus_rdata_o), DigestW'(rom_mem[prev_addr]), "bus_rdata_o");
      end
      prev_req  = bus_req_i;
      prev_addr = bus_addr_i;
    end
    @(negedge clk_i);
    bus_req_i = 1'b0;
    #1;
    // The response to the final request of the loop
    check_eq(DigestW'(bus_rvalid_o), DigestW'(prev_req), "bus_rvalid_o after Done");
    if (prev_req) begin
      check_eq(DigestW'(bus_rdata_o), DigestW'(rom_mem[prev_addr]), "bus_rdata_o");
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ROM model, address coverage and the alert watch
  // The request is taken after the falling-edge inputs have settled and before the
  // rising edge, then answered on the following falling edge
  initial begin
    rom_data_i = '0;
    rom_req_q  = 1'b0;
    rom_addr_q = '0;
    seen_q     = '0;
    forever begin
      @(negedge clk_i);
      if (rom_req_q) begin
        rom_data_i = rom_mem[rom_addr_q];
      end
      #1;
      rom_req_q  = rom_req_o;
      rom_addr_q = rom_addr_o;
      if (!rst_ni) begin
        seen_q = '0;
      end else begin
        if (rom_req_o && pwr_done_o != Mubi4True) begin
          seen_q[rom_addr_o] = 1'b1;
        end
        check_eq(DigestW'(alert_o), DigestW'(1'b0), "alert_o");
      end
    end
  end

  initial begin
    bit corrupt;
    void'($urandom(32'h5cc5));
    fail_cnt   = 0;
    rst_ni     = 1'b0;
    bus_req_i  = 1'b0;
    bus_addr_i = '0;
    for (int img = 0; img < NumImages; img++) begin
      // First image is clean and the second is spoiled so both outcomes are seen
      corrupt = (img == 1) || ((img > 1) && 1'($urandom));
      @(negedge clk_i);
      rst_ni    = 1'b0;
      bus_req_i = 1'b0;
      load_image(corrupt);
      repeat (2) @(negedge clk_i);
      rst_ni = 1'b1;
      wait_for_done();
      check_done_outputs(!corrupt);
      random_bus_reads();
    end
    if (fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rom_check_top.f */
hdl/rom_check_geom_pkg.sv
hdl/rom_check_status_pkg.sv
hdl/rom_check_counter.sv
hdl/rom_check_hash.sv
hdl/rom_check_compare.sv
hdl/rom_check_fsm.sv
hdl/rom_check_mux.sv
hdl/rom_check_top.sv
tests/rom_check_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module rom_check_tb -f rom_check_top.f &&
  ./obj_dir/Vrom_check_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx '>>> PASS' sim.log && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
